/* vlog.f */
src/replayPkg.sv
src/replayRecord.sv
src/replayStore.sv
src/replayRelease.sv
src/replayFlushFilter.sv
src/replayQueueTop.sv
verif/replayQueueTb.sv

/* Bender.yml */
package:
  name: replay_queue

sources:
  - src/replayPkg.sv
  - src/replayRecord.sv
  - src/replayStore.sv
  - src/replayRelease.sv
  - src/replayFlushFilter.sv
  - src/replayQueueTop.sv
  - target: simulation
    files:
      - verif/replayQueueTb.sv

/* verif/replayQueueTb.sv */
// Replay queue testbench
// Directed tests for idle behavior, single replay, gap spacing, a held load
// under back-pressure, and flush suppression
`default_nettype none

module replayQueueTb;

    timeunit 1ns;
    timeprecision 100ps;

    // Edges from the record being taken to the replay being seen
    localparam int ReplayLatency = 2;
    localparam int SettleCycles = 30;
    localparam int WaitLimit = 200;
    localparam int HeldSlot = 2;
    localparam int FlushSlot = 1;
    localparam int FlushFrom = 13;
    localparam int FlushTo = 16;

    logic clk;
    logic rstN;
    logic recValid;
    replayPkg::OpKind recKind;
    replayPkg::OpTag recTag;
    replayPkg::AlPtr recAlPtr;
    logic recWaitMiss;
    replayPkg::MissSlotIdx recMissSlot;
    logic [replayPkg::MissSlots-1:0] missReady;
    logic flushReq;
    replayPkg::AlPtr flushHead;
    replayPkg::AlPtr flushTail;
    logic replayValid;
    replayPkg::OpKind replayKind;
    replayPkg::OpTag replayTag;
    replayPkg::AlPtr replayAlPtr;
    logic stallUpper;
    logic flushedOpExist;

    int cycleCount;
    int checkCount;
    int errorCount;

    // Replays collected by the monitor
    int seenTags[$];
    int seenKinds[$];
    int seenPtrs[$];
    int seenCycles[$];

    replayQueueTop DUT (
        .clk            (clk),
        .rstN           (rstN),
        .recValid       (recValid),
        .recKind        (recKind),
        .recTag         (recTag),
        .recAlPtr       (recAlPtr),
        .recWaitMiss    (recWaitMiss),
        .recMissSlot    (recMissSlot),
        .missReady      (missReady),
        .flushReq       (flushReq),
        .flushHead      (flushHead),
        .flushTail      (flushTail),
        .replayValid    (replayValid),
        .replayKind     (replayKind),
        .replayTag      (replayTag),
        .replayAlPtr    (replayAlPtr),
        .stallUpper     (stallUpper),
        .flushedOpExist (flushedOpExist)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (rstN && replayValid) begin
            seenTags.push_back(int'(replayTag));
            seenKinds.push_back(int'(replayKind));
            seenPtrs.push_back(int'(replayAlPtr));
            seenCycles.push_back(cycleCount);
        end
    end

    task automatic checkValue(input string testName, input int expected, input int actual);
        checkCount++;
        if (expected != actual) begin
            errorCount++;
            $display("ERROR %s: expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic reportFailure(input string message);
        errorCount++;
        $display("%s", message);
    endtask

    task automatic clearSeen();
        seenTags.delete();
        seenKinds.delete();
        seenPtrs.delete();
        seenCycles.delete();
    endtask

    // Call right after a rising edge; the DUT takes the record at the next one
    task automatic setRecord(input replayPkg::OpKind kind, input replayPkg::AlPtr alPtr,
                             input logic waitMiss, input replayPkg::MissSlotIdx slot,
                             output int tag, output int takenCycle);
        replayPkg::OpTag newTag;
        newTag = replayPkg::OpTag'($urandom);
        recValid <= 1'b1;
        recKind <= kind;
        recTag <= newTag;
        recAlPtr <= alPtr;
        recWaitMiss <= waitMiss;
        recMissSlot <= slot;
        tag = int'(newTag);
        takenCycle = cycleCount + 1;
    endtask

    task automatic recordOp(input replayPkg::OpKind kind, input replayPkg::AlPtr alPtr,
                            input logic waitMiss, input replayPkg::MissSlotIdx slot,
                            output int tag, output int takenCycle);
        @(posedge clk);
        setRecord(kind, alPtr, waitMiss, slot, tag, takenCycle);
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clk);
            recValid <= 1'b0;
        end
    endtask

    task automatic waitReplays(input string testName, input int count);
        int waited;
        waited = 0;
        while (seenTags.size() < count && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (seenTags.size() < count) begin
            reportFailure($sformatf("Timeout in %s: only %0d of %0d ops replayed",
                                    testName, seenTags.size(), count));
        end
    endtask

    task automatic waitFlushLevel(input string testName, input logic level);
        int waited;
        waited = 0;
        while (flushedOpExist !== level && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (flushedOpExist !== level) begin
            reportFailure($sformatf("Timeout in %s: flushedOpExist never went to %0b",
                                    testName, level));
        end
    endtask

    task automatic compareTags(input string testName, input int expTags[$]);
        int i;
        checkValue({testName, " count"}, expTags.size(), seenTags.size());
        for (i = 0; i < expTags.size() && i < seenTags.size(); i++) begin
            checkValue({testName, " tag"}, expTags[i], seenTags[i]);
        end
    endtask

    task automatic idleAfterReset();
        repeat (10) begin
            @(negedge clk);
            checkValue("idleAfterReset replayValid", 0, int'(replayValid));
            checkValue("idleAfterReset stallUpper", 0, int'(stallUpper));
            checkValue("idleAfterReset flushedOpExist", 0, int'(flushedOpExist));
        end
    endtask

    task automatic singleReplay();
        int tag;
        int taken;
        clearSeen();
        recordOp(replayPkg::opInt, 6'd5, 1'b0, 2'd0, tag, taken);
        idleCycles(1);
        waitReplays("singleReplay", 1);
        if (seenTags.size() >= 1) begin
            checkValue("singleReplay tag", tag, seenTags[0]);
            checkValue("singleReplay kind", int'(replayPkg::opInt), seenKinds[0]);
            checkValue("singleReplay alPtr", 5, seenPtrs[0]);
            checkValue("singleReplay cycle", taken + ReplayLatency, seenCycles[0]);
        end
        // Bubbles behind the op must not show up as replays
        idleCycles(SettleCycles);
        checkValue("singleReplay count", 1, seenTags.size());
    endtask

    task automatic gapSpacing();
        int gaps[3];
        int tags[$];
        int taken[4];
        int tag;
        int i;
        gaps = '{1, 3, 2};
        clearSeen();
        recordOp(replayPkg::opInt, 6'd20, 1'b0, 2'd0, tag, taken[0]);
        tags.push_back(tag);
        for (i = 0; i < 3; i++) begin
            idleCycles(gaps[i] - 1);
            recordOp(replayPkg::opInt, replayPkg::AlPtr'(21 + i), 1'b0, 2'd0, tag,
                     taken[i + 1]);
            tags.push_back(tag);
        end
        idleCycles(1);
        waitReplays("gapSpacing", 4);
        compareTags("gapSpacing", tags);
        for (i = 0; i < 4 && i < seenCycles.size(); i++) begin
            checkValue("gapSpacing cycle", taken[i] + ReplayLatency, seenCycles[i]);
            if (i > 0) begin
                checkValue("gapSpacing gap", gaps[i - 1], seenCycles[i] - seenCycles[i - 1]);
            end
        end
        idleCycles(SettleCycles);
    endtask

    task automatic missHold();
        int expTags[$];
        int tag;
        int taken;
        int waited;
        logic stalled;
        clearSeen();
        @(posedge clk);
        missReady[HeldSlot] <= 1'b0;
        recordOp(replayPkg::opLoad, 6'd30, 1'b1, 2'(HeldSlot), tag, taken);
        expTags.push_back(tag);
        // Keep recording until the queue pushes back
        stalled = 1'b0;
        waited = 0;
        while (!stalled && waited < replayPkg::QueueDepth) begin
            @(negedge clk);
            stalled = stallUpper;
            @(posedge clk);
            if (stalled) begin
                recValid <= 1'b0;
            end else begin
                setRecord(replayPkg::opInt, replayPkg::AlPtr'(31 + waited), 1'b0, 2'd0,
                          tag, taken);
                expTags.push_back(tag);
            end
            waited++;
        end
        if (!stalled) begin
            @(posedge clk);
            recValid <= 1'b0;
            reportFailure("missHold: stallUpper never rose while the load was held");
        end
        idleCycles(5);
        @(negedge clk);
        checkValue("missHold replays while held", 0, seenTags.size());
        @(posedge clk);
        missReady[HeldSlot] <= 1'b1;
        waitReplays("missHold", expTags.size());
        compareTags("missHold", expTags);
        idleCycles(SettleCycles);
        checkValue("missHold final count", expTags.size(), seenTags.size());
    endtask

    task automatic flushSuppress();
        int expTags[$];
        int tag;
        int taken;
        int ptr;
        clearSeen();
        @(posedge clk);
        missReady[FlushSlot] <= 1'b0;
        // Held load at the head keeps the later ops queued across the flush
        for (ptr = 10; ptr <= 18; ptr++) begin
            if (ptr == 10) begin
                recordOp(replayPkg::opLoad, 6'd10, 1'b1, 2'(FlushSlot), tag, taken);
            end else begin
                recordOp(replayPkg::opInt, replayPkg::AlPtr'(ptr), 1'b0, 2'd0, tag, taken);
            end
            if (ptr < FlushFrom || ptr >= FlushTo) begin
                expTags.push_back(tag);
            end
        end
        idleCycles(6);
        @(posedge clk);
        flushReq <= 1'b1;
        flushHead <= replayPkg::AlPtr'(FlushFrom);
        flushTail <= replayPkg::AlPtr'(FlushTo);
        @(posedge clk);
        flushReq <= 1'b0;
        waitFlushLevel("flushSuppress rise", 1'b1);
        @(posedge clk);
        missReady[FlushSlot] <= 1'b1;
        waitReplays("flushSuppress", expTags.size());
        compareTags("flushSuppress", expTags);
        waitFlushLevel("flushSuppress fall", 1'b0);
        idleCycles(SettleCycles);
        checkValue("flushSuppress final count", expTags.size(), seenTags.size());
    endtask

    initial begin
        int seedValue;
        seedValue = $urandom(95);
        clk = 1'b0;
        rstN = 1'b0;
        recValid = 1'b0;
        recKind = replayPkg::opInt;
        recTag = '0;
        recAlPtr = '0;
        recWaitMiss = 1'b0;
        recMissSlot = '0;
        missReady = '1;
        flushReq = 1'b0;
        flushHead = '0;
        flushTail = '0;
        cycleCount = 0;
        checkCount = 0;
        errorCount = 0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        idleAfterReset();
        singleReplay();
        gapSpacing();
        missHold();
        flushSuppress();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/replayQueueTop.sv */
// Replay queue top level
// Chains the record stage, the queue storage, the release stage and the
// output flush filter
`default_nettype none

module replayQueueTop (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic                          recValid,
    input  wire replayPkg::OpKind              recKind,
    input  wire replayPkg::OpTag               recTag,
    input  wire replayPkg::AlPtr               recAlPtr,
    input  wire logic                          recWaitMiss,
    input  wire replayPkg::MissSlotIdx         recMissSlot,
    input  wire logic [replayPkg::MissSlots-1:0] missReady,
    input  wire logic                          flushReq,
    input  wire replayPkg::AlPtr               flushHead,
    input  wire replayPkg::AlPtr               flushTail,
    output logic                               replayValid,
    output replayPkg::OpKind                   replayKind,
    output replayPkg::OpTag                    replayTag,
    output replayPkg::AlPtr                    replayAlPtr,
    output logic                               stallUpper,
    output logic                               flushedOpExist
);

    logic pushEn;
    logic pushOpValid;
    replayPkg::IntervalT pushInterval;
    logic pushTaken;
    logic anyValidOps;

    logic headPresent;
    logic headOpValid;
    replayPkg::IntervalT headInterval;
    replayPkg::OpKind headKind;
    replayPkg::OpTag headTag;
    replayPkg::AlPtr headAlPtr;
    logic headWaitMiss;
    replayPkg::MissSlotIdx headMissSlot;
    replayPkg::QueueCount entryCount;
    logic almostFull;
    logic popEn;

    replayRecord record (
        .clk          (clk),
        .rstN         (rstN),
        .recValid     (recValid),
        .pushTaken    (pushTaken),
        .anyValidOps  (anyValidOps),
        .pushEn       (pushEn),
        .pushOpValid  (pushOpValid),
        .pushInterval (pushInterval)
    );

    replayStore store (
        .clk          (clk),
        .rstN         (rstN),
        .pushEn       (pushEn),
        .pushOpValid  (pushOpValid),
        .pushInterval (pushInterval),
        .pushKind     (recKind),
        .pushTag      (recTag),
        .pushAlPtr    (recAlPtr),
        .pushWaitMiss (recWaitMiss),
        .pushMissSlot (recMissSlot),
        .popEn        (popEn),
        .pushTaken    (pushTaken),
        .anyValidOps  (anyValidOps),
        .headPresent  (headPresent),
        .headOpValid  (headOpValid),
        .headInterval (headInterval),
        .headKind     (headKind),
        .headTag      (headTag),
        .headAlPtr    (headAlPtr),
        .headWaitMiss (headWaitMiss),
        .headMissSlot (headMissSlot),
        .entryCount   (entryCount),
        .almostFull   (almostFull)
    );

    replayRelease releaseStage (
        .clk          (clk),
        .rstN         (rstN),
        .headPresent  (headPresent),
        .headOpValid  (headOpValid),
        .headInterval (headInterval),
        .headKind     (headKind),
        .headWaitMiss (headWaitMiss),
        .headMissSlot (headMissSlot),
        .missReady    (missReady),
        .popEn        (popEn)
    );

    replayFlushFilter filter (
        .clk            (clk),
        .rstN           (rstN),
        .popEn          (popEn),
        .headOpValid    (headOpValid),
        .headKind       (headKind),
        .headTag        (headTag),
        .headAlPtr      (headAlPtr),
        .entryCount     (entryCount),
        .almostFull     (almostFull),
        .flushReq       (flushReq),
        .flushHead      (flushHead),
        .flushTail      (flushTail),
        .replayValid    (replayValid),
        .replayKind     (replayKind),
        .replayTag      (replayTag),
        .replayAlPtr    (replayAlPtr),
        .stallUpper     (stallUpper),
        .flushedOpExist (flushedOpExist)
    );

endmodule

`default_nettype wire

/* src/replayFlushFilter.sv */
// Replay queue output and flush filter
// Registers each popped op, suppresses ops inside a flushed active-list
// range while entries from before the flush drain, and drives the stall
`default_nettype none

module replayFlushFilter (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   popEn,
    input  wire logic                   headOpValid,
    input  wire replayPkg::OpKind       headKind,
    input  wire replayPkg::OpTag        headTag,
    input  wire replayPkg::AlPtr        headAlPtr,
    input  wire replayPkg::QueueCount   entryCount,
    input  wire logic                   almostFull,
    input  wire logic                   flushReq,
    input  wire replayPkg::AlPtr        flushHead,
    input  wire replayPkg::AlPtr        flushTail,
    output logic                        replayValid,
    output replayPkg::OpKind            replayKind,
    output replayPkg::OpTag             replayTag,
    output replayPkg::AlPtr             replayAlPtr,
    output logic                        stallUpper,
    output logic                        flushedOpExist
);

    logic popReg;
    logic replayReg;
    replayPkg::OpKind kindReg;
    replayPkg::OpTag tagReg;
    replayPkg::AlPtr alPtrReg;

    // Entries still queued from before the flush
    replayPkg::QueueCount window;
    replayPkg::AlPtr rangeHead;
    replayPkg::AlPtr rangeTail;
    logic flushedByWindow;
    logic flushedNow;

    assign flushedByWindow = (window != '0)
                          && replayPkg::inFlushRange(rangeHead, rangeTail, alPtrReg);
    // The op already in the output register is checked against the new range
    assign flushedNow = flushReq && replayPkg::inFlushRange(flushHead, flushTail, alPtrReg);

    assign replayValid = replayReg && !flushedByWindow && !flushedNow;
    assign replayKind = kindReg;
    assign replayTag = tagReg;
    assign replayAlPtr = alPtrReg;
    assign stallUpper = replayReg || almostFull;
    assign flushedOpExist = (window != '0);

    always_ff @(posedge clk) begin
        if (popEn) begin
            kindReg <= headKind;
            tagReg <= headTag;
            alPtrReg <= headAlPtr;
        end
        if (flushReq) begin
            rangeHead <= flushHead;
            rangeTail <= flushTail;
        end
    end

    // Every pop counts down the window, bubbles included, so it always drains
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            popReg <= 1'b0;
            replayReg <= 1'b0;
            window <= '0;
        end else begin
            popReg <= popEn;
            replayReg <= popEn && headOpValid;
            if (flushReq) begin
                window <= entryCount;
            end else if (popReg && (window != '0)) begin
                window <= window - replayPkg::QueueCount'(1);
            end
        end
    end

    // Window never outlasts the entries queued before the flush
    windowWithinQueue: assert property (@(posedge clk) disable iff (!rstN)
        window <= entryCount + replayPkg::QueueCount'(popReg))
        else $error("flush window larger than the entries left in the queue");

endmodule

`default_nettype wire

/* src/replayRelease.sv */
// Replay queue release stage
// Pops the head once the cycles since the last pop reach its recorded gap,
// and holds a load whose miss slot has not yet received its data
`default_nettype none

module replayRelease (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic                          headPresent,
    input  wire logic                          headOpValid,
    input  wire replayPkg::IntervalT           headInterval,
    input  wire replayPkg::OpKind              headKind,
    input  wire logic                          headWaitMiss,
    input  wire replayPkg::MissSlotIdx         headMissSlot,
    input  wire logic [replayPkg::MissSlots-1:0] missReady,
    output logic                               popEn
);

    replayPkg::IntervalT gapCount;
    logic gapReached;
    logic loadHeld;

    assign gapReached = (gapCount >= headInterval);

    // Only a real load that missed can wait, bubbles never do
    assign loadHeld = headOpValid
                   && (headKind == replayPkg::opLoad)
                   && headWaitMiss
                   && !missReady[headMissSlot];

    assign popEn = headPresent && gapReached && !loadHeld;

    // While a load is held the counter saturates, so the head goes out as
    // soon as its slot is ready and the following gaps stay as recorded
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gapCount <= replayPkg::IntervalT'(replayPkg::MaxInterval);
        end else if (popEn) begin
            gapCount <= '0;
        end else if (gapCount < replayPkg::IntervalT'(replayPkg::MaxInterval)) begin
            gapCount <= gapCount + replayPkg::IntervalT'(1);
        end
    end

endmodule

`default_nettype wire

/* src/replayStore.sv */
// Replay queue storage
// Circular entry array with head and tail pointers, the entry count and the
// count of entries that carry a real op; the head is read combinationally
`default_nettype none

module replayStore (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire logic                    pushEn,
    input  wire logic                    pushOpValid,
    input  wire replayPkg::IntervalT     pushInterval,
    input  wire replayPkg::OpKind        pushKind,
    input  wire replayPkg::OpTag         pushTag,
    input  wire replayPkg::AlPtr         pushAlPtr,
    input  wire logic                    pushWaitMiss,
    input  wire replayPkg::MissSlotIdx   pushMissSlot,
    input  wire logic                    popEn,
    output logic                         pushTaken,
    output logic                         anyValidOps,
    output logic                         headPresent,
    output logic                         headOpValid,
    output replayPkg::IntervalT          headInterval,
    output replayPkg::OpKind             headKind,
    output replayPkg::OpTag              headTag,
    output replayPkg::AlPtr              headAlPtr,
    output logic                         headWaitMiss,
    output replayPkg::MissSlotIdx        headMissSlot,
    output replayPkg::QueueCount         entryCount,
    output logic                         almostFull
);

    logic                  opValidMem  [replayPkg::QueueDepth];
    replayPkg::IntervalT   intervalMem [replayPkg::QueueDepth];
    replayPkg::OpKind      kindMem     [replayPkg::QueueDepth];
    replayPkg::OpTag       tagMem      [replayPkg::QueueDepth];
    replayPkg::AlPtr       alPtrMem    [replayPkg::QueueDepth];
    logic                  waitMissMem [replayPkg::QueueDepth];
    replayPkg::MissSlotIdx missSlotMem [replayPkg::QueueDepth];

    replayPkg::QueueIdx   headPtr;
    replayPkg::QueueIdx   tailPtr;
    replayPkg::QueueCount count;
    replayPkg::QueueCount countNext;
    replayPkg::QueueCount validCount;
    replayPkg::QueueCount validCountNext;

    assign pushTaken = pushEn && (count != replayPkg::QueueCount'(replayPkg::QueueDepth));
    assign headPresent = (count != '0);
    assign anyValidOps = (validCount != '0);
    assign entryCount = count;
    assign almostFull = (count >= replayPkg::QueueCount'(replayPkg::AlmostFullLevel));

    assign headOpValid = opValidMem[headPtr];
    assign headInterval = intervalMem[headPtr];
    assign headKind = kindMem[headPtr];
    assign headTag = tagMem[headPtr];
    assign headAlPtr = alPtrMem[headPtr];
    assign headWaitMiss = waitMissMem[headPtr];
    assign headMissSlot = missSlotMem[headPtr];

    always_ff @(posedge clk) begin
        if (pushTaken) begin
            opValidMem[tailPtr] <= pushOpValid;
            intervalMem[tailPtr] <= pushInterval;
            kindMem[tailPtr] <= pushKind;
            tagMem[tailPtr] <= pushTag;
            alPtrMem[tailPtr] <= pushAlPtr;
            waitMissMem[tailPtr] <= pushWaitMiss;
            missSlotMem[tailPtr] <= pushMissSlot;
        end
    end

    always_comb begin
        countNext = count;
        validCountNext = validCount;
        if (pushTaken) begin
            countNext = countNext + replayPkg::QueueCount'(1);
            if (pushOpValid) begin
                validCountNext = validCountNext + replayPkg::QueueCount'(1);
            end
        end
        if (popEn) begin
            countNext = countNext - replayPkg::QueueCount'(1);
            if (headOpValid) begin
                validCountNext = validCountNext - replayPkg::QueueCount'(1);
            end
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            validCount <= '0;
        end else begin
            if (pushTaken) begin
                tailPtr <= tailPtr + replayPkg::QueueIdx'(1);
            end
            if (popEn) begin
                headPtr <= headPtr + replayPkg::QueueIdx'(1);
            end
            count <= countNext;
            validCount <= validCountNext;
        end
    end

    // Release stage must only pop a present head
    popWhileEmpty: assert property (@(posedge clk) disable iff (!rstN)
        popEn |-> headPresent)
        else $error("replay queue popped while empty");

    // Environment must stop recording within the stall latency
    recordLostWhileFull: assert property (@(posedge clk) disable iff (!rstN)
        (pushEn && pushOpValid) |-> pushTaken)
        else $error("valid record lost while replay queue full");

endmodule

`default_nettype wire

/* src/replayRecord.sv */
// Replay queue record stage
// Measures the gap since the last accepted push and issues a push for each
// recorded op, or a bubble entry while real ops are still queued
`default_nettype none

module replayRecord (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              recValid,
    input  wire logic              pushTaken,
    input  wire logic              anyValidOps,
    output logic                   pushEn,
    output logic                   pushOpValid,
    output replayPkg::IntervalT    pushInterval
);

    replayPkg::IntervalT gapCount;

    // Bubbles keep the spacing between ops that are already queued
    assign pushEn = recValid || anyValidOps;
    assign pushOpValid = recValid;
    assign pushInterval = gapCount;

    // Saturating count of cycles since the last push the store accepted
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gapCount <= replayPkg::IntervalT'(replayPkg::MaxInterval);
        end else if (pushTaken) begin
            gapCount <= '0;
        end else if (gapCount < replayPkg::IntervalT'(replayPkg::MaxInterval)) begin
            gapCount <= gapCount + replayPkg::IntervalT'(1);
        end
    end

endmodule

`default_nettype wire

/* src/replayPkg.sv */
// Replay queue package
// Sizes, payload types, the op-kind enum and the flush range check shared
// by every stage of the replay queue
`default_nettype none

package replayPkg;

    localparam int QueueDepth = 16;
    localparam int MaxInterval = 7;
    // Records that can still arrive after the stall goes up
    localparam int RecordLatency = 3;
    localparam int AlmostFullLevel = QueueDepth - RecordLatency;
    localparam int MissSlots = 4;

    typedef logic [$clog2(QueueDepth)-1:0] QueueIdx;
    typedef logic [$clog2(QueueDepth):0] QueueCount;
    typedef logic [$clog2(MaxInterval+1)-1:0] IntervalT;
    typedef logic [5:0] AlPtr;
    typedef logic [$clog2(MissSlots)-1:0] MissSlotIdx;
    typedef logic [7:0] OpTag;

    typedef enum logic [1:0] {
        opInt   = 2'd0,
        opLoad  = 2'd1,
        opStore = 2'd2
    } OpKind;

    // Head is inclusive and tail exclusive, the range may wrap past zero
    function automatic logic inFlushRange(input AlPtr head, input AlPtr tail, input AlPtr ptr);
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end else begin
            return (ptr >= head) || (ptr < tail);
        end
    endfunction

endpackage

`default_nettype wire
